// ==== dcache_nxt_lv_mem.f ====
+incdir+.
icb_pkg.sv
dcache_arb_pkg.sv
reg_fifo.sv
dcache_nxt_lv_mem_icb.sv
dcache_nxt_lv_mem.sv
tb_dcache_nxt_lv_mem.sv

// ==== tb_dcache_nxt_lv_mem.sv ====
// testbench for the dcache next-level memory path
// line-fill and write-back drivers, ICB memory model, reference model and scoreboard
`timescale 1ns/100ps
`include "dcache_mem_cfg.svh"

module tb_dcache_nxt_lv_mem;

	import icb_pkg::*;

	localparam int clk_period = 20;
	localparam int n_rr       = 8;  // per side, both valid back to back
	localparam int n_rand     = 40; // per side, random valid and readies
	localparam int n_ops      = 2 * (n_rr + n_rand);

	logic      aclk;
	logic      aresetn;
	icb_addr_t rd_cmd_addr, wt_cmd_addr, mem_cmd_addr;
	icb_data_t rd_cmd_wdata, wt_cmd_wdata, mem_cmd_wdata;
	icb_data_t rd_rsp_rdata, wt_rsp_rdata, mem_rsp_rdata;
	icb_mask_t rd_cmd_wmask, wt_cmd_wmask, mem_cmd_wmask;
	logic      rd_cmd_read, rd_cmd_valid, rd_cmd_ready;
	logic      rd_rsp_err, rd_rsp_valid, rd_rsp_ready;
	logic      wt_cmd_read, wt_cmd_valid, wt_cmd_ready;
	logic      wt_rsp_err, wt_rsp_valid, wt_rsp_ready;
	logic      mem_cmd_read, mem_cmd_valid, mem_cmd_ready;
	logic      mem_rsp_err, mem_rsp_valid, mem_rsp_ready;

	icb_cmd_t    rd_ops[$];          // line-fill stream, reads only
	icb_cmd_t    wt_ops[$];          // write-back stream, writes only
	icb_rsp_t    rd_exp[$];          // expected, in acceptance order
	icb_rsp_t    wt_exp[$];
	icb_rsp_t    mem_q[$];           // model answers not yet transferred
	icb_data_t   mem_arr [256];      // memory model storage
	icb_data_t   shadow [256];       // reference copy
	logic [31:0] seed = 32'h8bd1c163;
	int          rd_idx, wt_idx;     // commands accepted
	int          rd_done, wt_done;   // responses delivered
	int          rr_left;            // mem commands still under the alternation check
	int          errors;
	logic        rd_pend, wt_pend;   // command offered, not yet taken
	logic        mrsp_busy;          // model response on the bus
	logic        rr_next_rd;
	logic        running;

	dcache_nxt_lv_mem u_dcache_nxt_lv_mem (.*);

	always #(clk_period / 2) aclk = ~aclk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function logic [31:0] rand32();
		seed = xorshift(seed);
		return seed;
	endfunction

	// power-up content, every address bit matters
	function automatic icb_data_t fill_word(input logic [7:0] w);
		return {w ^ 8'h5a, ~w, 8'(w * 8'h1d), w};
	endfunction

	// expected response, also applies a write to the shadow copy
	function automatic icb_rsp_t ref_access(ref icb_data_t smem [256], input icb_cmd_t cmd);
		logic [7:0] word;
		icb_rsp_t   rsp;
		int         b;
		word      = cmd.addr[9:2];
		rsp.err   = (word >= 8'd240); // top 16 words answer with error
		rsp.rdata = '0;               // writes return zero data
		if (cmd.read)
			rsp.rdata = smem[word];
		else
			for (b = 0; b < 4; b++)
				if (cmd.wmask[b])
					smem[word][8*b +: 8] = cmd.wdata[8*b +: 8];
		return rsp;
	endfunction

	task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic check_idle(input string when);
		check_eq(rd_rsp_valid, 1'b0, {"rd_rsp_valid ", when});
		check_eq(wt_rsp_valid, 1'b0, {"wt_rsp_valid ", when});
		check_eq(mem_cmd_valid, 1'b0, {"mem_cmd_valid ", when});
	endtask

	// all stimulus on the falling edge, one process so the random order is fixed
	always @(negedge aclk)
	begin : drive
		logic [31:0] r;
		if (running)
		begin
			r = rand32();
			if (!rd_pend)
			begin
				rd_cmd_valid = 1'b0;
				if (rd_idx < rd_ops.size() && (rd_idx < n_rr || r[0]))
				begin
					{rd_cmd_addr, rd_cmd_read, rd_cmd_wdata, rd_cmd_wmask} = rd_ops[rd_idx];
					rd_cmd_valid = 1'b1;
					rd_pend      = 1'b1;
				end
			end
			if (!wt_pend)
			begin
				wt_cmd_valid = 1'b0;
				if (wt_idx < wt_ops.size() && (wt_idx < n_rr || r[1]))
				begin
					{wt_cmd_addr, wt_cmd_read, wt_cmd_wdata, wt_cmd_wmask} = wt_ops[wt_idx];
					wt_cmd_valid = 1'b1;
					wt_pend      = 1'b1;
				end
			end
			rd_rsp_ready  = (r[3:2] != 2'b00); // about 3 in 4
			wt_rsp_ready  = (r[5:4] != 2'b00);
			mem_cmd_ready = (r[7:6] != 2'b00);
			if (!mrsp_busy)
			begin
				mem_rsp_valid = 1'b0;
				if (mem_q.size() > 0 && r[8]) // random answer delay
				begin
					{mem_rsp_rdata, mem_rsp_err} = mem_q[0];
					mem_rsp_valid = 1'b1;
					mrsp_busy     = 1'b1;
				end
			end
			check_eq((rd_idx + wt_idx - rd_done - wt_done) <= `DCACHE_ROUTE_DEPTH, 1'b1,
				"outstanding commands within route depth");
		end
	end

	// command acceptance and the ICB memory model
	always @(posedge aclk)
	begin : cmd_side
		logic [7:0] w;
		icb_data_t  bmask;
		icb_rsp_t   rsp;
		if (rd_cmd_valid && rd_cmd_ready)
		begin
			rd_exp.push_back(ref_access(shadow, rd_ops[rd_idx]));
			rd_idx++;
			rd_pend = 1'b0;
		end
		if (wt_cmd_valid && wt_cmd_ready)
		begin
			wt_exp.push_back(ref_access(shadow, wt_ops[wt_idx]));
			wt_idx++;
			wt_pend = 1'b0;
		end
		if (mem_cmd_valid && mem_cmd_ready)
		begin
			w         = mem_cmd_addr[9:2];
			bmask     = {{8{mem_cmd_wmask[3]}}, {8{mem_cmd_wmask[2]}},
			             {8{mem_cmd_wmask[1]}}, {8{mem_cmd_wmask[0]}}};
			rsp.err   = (w[7:4] == 4'hf); // error region
			rsp.rdata = mem_cmd_read ? mem_arr[w] : '0;
			if (!mem_cmd_read)
				mem_arr[w] = (mem_arr[w] & ~bmask) | (mem_cmd_wdata & bmask);
			mem_q.push_back(rsp); // answered in order
			if (rr_left > 0)
			begin
				check_eq(mem_cmd_read, rr_next_rd, "round-robin source at mem_cmd");
				rr_next_rd = ~rr_next_rd;
				rr_left--;
			end
		end
		if (mem_rsp_valid && mem_rsp_ready)
		begin
			void'(mem_q.pop_front());
			mrsp_busy = 1'b0;
		end
	end

	// scoreboard, one expected entry per requester response
	always @(posedge aclk)
	begin : compare
		icb_rsp_t exp;
		if (rd_rsp_valid && rd_rsp_ready)
		begin
			if (rd_exp.size() == 0)
			begin
				errors++;
				$display("read requester got a response it never asked for at %0t ns", $time);
			end
			else
			begin
				exp = rd_exp.pop_front();
				check_eq(rd_rsp_rdata, exp.rdata, "read requester rdata");
				check_eq(rd_rsp_err, exp.err, "read requester err");
			end
			rd_done++;
		end
		if (wt_rsp_valid && wt_rsp_ready)
		begin
			if (wt_exp.size() == 0)
			begin
				errors++;
				$display("write requester got a response it never asked for at %0t ns", $time);
			end
			else
			begin
				exp = wt_exp.pop_front();
				check_eq(wt_rsp_rdata, exp.rdata, "write requester rdata");
				check_eq(wt_rsp_err, exp.err, "write requester err");
			end
			wt_done++;
		end
	end

	initial
	begin : main
		logic [31:0] r;
		logic [7:0]  w;
		logic [7:0]  prev_w;
		aclk    = 1'b0;
		aresetn = 1'b0;
		{rd_cmd_addr, rd_cmd_read, rd_cmd_wdata, rd_cmd_wmask, rd_cmd_valid, rd_rsp_ready} = '0;
		{wt_cmd_addr, wt_cmd_read, wt_cmd_wdata, wt_cmd_wmask, wt_cmd_valid, wt_rsp_ready} = '0;
		{mem_cmd_ready, mem_rsp_rdata, mem_rsp_err, mem_rsp_valid} = '0;
		{rd_pend, wt_pend, mrsp_busy, running} = '0;
		errors     = 0;
		rr_left    = 2 * n_rr; // first commands alternate, read first
		rr_next_rd = 1'b1;
		for (int i = 0; i < 256; i++)
		begin
			mem_arr[i] = fill_word(8'(i));
			shadow[i]  = fill_word(8'(i));
		end
		// back-to-back phase, each read hits the word of the write before it
		prev_w = 8'd17;
		for (int k = 0; k < n_rr; k++)
		begin
			r = rand32();
			w = (k == 3) ? 8'd250 : r[7:0]; // one pair in the error region
			rd_ops.push_back('{addr: {22'd0, prev_w, 2'b00}, read: 1'b1, wdata: '0, wmask: '0});
			wt_ops.push_back('{addr: {22'd0, w, 2'b00}, read: 1'b0, wdata: rand32(),
				wmask: r[11:8]});
			prev_w = w;
		end
		// random phase, words 0..31 and 224..255 so accesses collide
		for (int k = 0; k < n_rand; k++)
		begin
			r = rand32();
			w = {{3{r[7]}}, r[4:0]};
			rd_ops.push_back('{addr: {22'd0, w, 2'b00}, read: 1'b1, wdata: '0, wmask: '0});
			w = {{3{r[15]}}, r[12:8]};
			wt_ops.push_back('{addr: {22'd0, w, 2'b00}, read: 1'b0, wdata: rand32(),
				wmask: r[19:16]});
		end
		repeat (5)
		begin
			@(negedge aclk);
			check_idle("during reset");
		end
		aresetn = 1'b1;
		@(negedge aclk);
		check_idle("first cycle after reset");
		@(posedge aclk);
		running = 1'b1;
		wait (rd_done == rd_ops.size() && wt_done == wt_ops.size());
		repeat (4) @(negedge aclk);
		check_idle("after the last response");
		check_eq(rd_exp.size() + wt_exp.size(), 0, "expected responses left over");
		check_eq(mem_q.size(), 0, "memory answers left over");
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	// bound of 64 cycles per operation
	initial
	begin : watchdog
		#(n_ops * 64 * clk_period);
		$display("watchdog expired after %0d cycles, a response never arrived", n_ops * 64);
		$display("Simulation failed");
		$finish;
	end

endmodule

// ==== dcache_nxt_lv_mem.sv ====
// dcache path to next-level memory
// arbiter, then a command slice toward memory and a response slice back from it
`timescale 1ns/100ps
`include "dcache_mem_cfg.svh"

module dcache_nxt_lv_mem (
	input  logic               aclk,
	input  logic               aresetn,

	// line-fill requester
	input  icb_pkg::icb_addr_t rd_cmd_addr,
	input  logic               rd_cmd_read,
	input  icb_pkg::icb_data_t rd_cmd_wdata,
	input  icb_pkg::icb_mask_t rd_cmd_wmask,
	input  logic               rd_cmd_valid,
	output logic               rd_cmd_ready,
	output icb_pkg::icb_data_t rd_rsp_rdata,
	output logic               rd_rsp_err,
	output logic               rd_rsp_valid,
	input  logic               rd_rsp_ready,

	// write-back requester
	input  icb_pkg::icb_addr_t wt_cmd_addr,
	input  logic               wt_cmd_read,
	input  icb_pkg::icb_data_t wt_cmd_wdata,
	input  icb_pkg::icb_mask_t wt_cmd_wmask,
	input  logic               wt_cmd_valid,
	output logic               wt_cmd_ready,
	output icb_pkg::icb_data_t wt_rsp_rdata,
	output logic               wt_rsp_err,
	output logic               wt_rsp_valid,
	input  logic               wt_rsp_ready,

	// next-level memory, ICB master
	output icb_pkg::icb_addr_t mem_cmd_addr,
	output logic               mem_cmd_read,
	output icb_pkg::icb_data_t mem_cmd_wdata,
	output icb_pkg::icb_mask_t mem_cmd_wmask,
	output logic               mem_cmd_valid,
	input  logic               mem_cmd_ready,
	input  icb_pkg::icb_data_t mem_rsp_rdata,
	input  logic               mem_rsp_err,
	input  logic               mem_rsp_valid,
	output logic               mem_rsp_ready
);

	import icb_pkg::*;

	// arbiter to command slice
	icb_addr_t arb_cmd_addr;
	logic      arb_cmd_read;
	icb_data_t arb_cmd_wdata;
	icb_mask_t arb_cmd_wmask;
	logic      arb_cmd_valid;
	logic      arb_cmd_ready;
	// response slice to arbiter
	icb_data_t arb_rsp_rdata;
	logic      arb_rsp_err;
	logic      arb_rsp_valid;
	logic      arb_rsp_ready;

	icb_cmd_t  arb_cmd_pkt; // slice payloads
	icb_cmd_t  mem_cmd_pkt;
	icb_rsp_t  mem_rsp_pkt;
	icb_rsp_t  arb_rsp_pkt;

	dcache_nxt_lv_mem_icb #(
		.arb_method    (`DCACHE_ARB_METHOD)
	) u_arb (
		.aclk          (aclk),
		.aresetn       (aresetn),
		.rd_cmd_addr   (rd_cmd_addr),
		.rd_cmd_read   (rd_cmd_read),
		.rd_cmd_wdata  (rd_cmd_wdata),
		.rd_cmd_wmask  (rd_cmd_wmask),
		.rd_cmd_valid  (rd_cmd_valid),
		.rd_cmd_ready  (rd_cmd_ready),
		.rd_rsp_rdata  (rd_rsp_rdata),
		.rd_rsp_err    (rd_rsp_err),
		.rd_rsp_valid  (rd_rsp_valid),
		.rd_rsp_ready  (rd_rsp_ready),
		.wt_cmd_addr   (wt_cmd_addr),
		.wt_cmd_read   (wt_cmd_read),
		.wt_cmd_wdata  (wt_cmd_wdata),
		.wt_cmd_wmask  (wt_cmd_wmask),
		.wt_cmd_valid  (wt_cmd_valid),
		.wt_cmd_ready  (wt_cmd_ready),
		.wt_rsp_rdata  (wt_rsp_rdata),
		.wt_rsp_err    (wt_rsp_err),
		.wt_rsp_valid  (wt_rsp_valid),
		.wt_rsp_ready  (wt_rsp_ready),
		.arb_cmd_addr  (arb_cmd_addr),
		.arb_cmd_read  (arb_cmd_read),
		.arb_cmd_wdata (arb_cmd_wdata),
		.arb_cmd_wmask (arb_cmd_wmask),
		.arb_cmd_valid (arb_cmd_valid),
		.arb_cmd_ready (arb_cmd_ready),
		.arb_rsp_rdata (arb_rsp_rdata),
		.arb_rsp_err   (arb_rsp_err),
		.arb_rsp_valid (arb_rsp_valid),
		.arb_rsp_ready (arb_rsp_ready)
	);

	// command fields packed for the slice, unpacked toward memory
	assign arb_cmd_pkt   = '{addr: arb_cmd_addr, read: arb_cmd_read,
	                         wdata: arb_cmd_wdata, wmask: arb_cmd_wmask};
	assign mem_cmd_addr  = mem_cmd_pkt.addr;
	assign mem_cmd_read  = mem_cmd_pkt.read;
	assign mem_cmd_wdata = mem_cmd_pkt.wdata;
	assign mem_cmd_wmask = mem_cmd_pkt.wmask;

	reg_fifo #(
		.payload_t (icb_cmd_t),
		.depth     (`DCACHE_SLICE_DEPTH)
	) u_cmd_slice (
		.aclk      (aclk),
		.aresetn   (aresetn),
		.in_valid  (arb_cmd_valid),
		.in_ready  (arb_cmd_ready), // full slice stalls both requesters
		.in_data   (arb_cmd_pkt),
		.out_valid (mem_cmd_valid),
		.out_ready (mem_cmd_ready),
		.out_data  (mem_cmd_pkt)
	);

	// response fields, memory into slice, slice into arbiter
	assign mem_rsp_pkt   = '{rdata: mem_rsp_rdata, err: mem_rsp_err};
	assign arb_rsp_rdata = arb_rsp_pkt.rdata;
	assign arb_rsp_err   = arb_rsp_pkt.err;

	reg_fifo #(
		.payload_t (icb_rsp_t),
		.depth     (`DCACHE_SLICE_DEPTH)
	) u_rsp_slice (
		.aclk      (aclk),
		.aresetn   (aresetn),
		.in_valid  (mem_rsp_valid),
		.in_ready  (mem_rsp_ready), // low once a stalled requester fills it
		.in_data   (mem_rsp_pkt),
		.out_valid (arb_rsp_valid),
		.out_ready (arb_rsp_ready),
		.out_data  (arb_rsp_pkt)
	);

endmodule

// ==== dcache_nxt_lv_mem_icb.sv ====
// arbiter between dcache line-fill and write-back ICB requesters
// records the winner in a route-tag queue and steers each response back by that tag
`timescale 1ns/100ps
`include "dcache_mem_cfg.svh"

module dcache_nxt_lv_mem_icb #(
	parameter dcache_arb_pkg::arb_method_e arb_method = `DCACHE_ARB_METHOD
)(
	input  logic              aclk,
	input  logic              aresetn,

	// line-fill requester, command
	input  icb_pkg::icb_addr_t rd_cmd_addr,
	input  logic               rd_cmd_read,
	input  icb_pkg::icb_data_t rd_cmd_wdata,
	input  icb_pkg::icb_mask_t rd_cmd_wmask,
	input  logic               rd_cmd_valid,
	output logic               rd_cmd_ready,
	// line-fill requester, response
	output icb_pkg::icb_data_t rd_rsp_rdata,
	output logic               rd_rsp_err,
	output logic               rd_rsp_valid,
	input  logic               rd_rsp_ready,

	// write-back requester, command
	input  icb_pkg::icb_addr_t wt_cmd_addr,
	input  logic               wt_cmd_read,
	input  icb_pkg::icb_data_t wt_cmd_wdata,
	input  icb_pkg::icb_mask_t wt_cmd_wmask,
	input  logic               wt_cmd_valid,
	output logic               wt_cmd_ready,
	// write-back requester, response
	output icb_pkg::icb_data_t wt_rsp_rdata,
	output logic               wt_rsp_err,
	output logic               wt_rsp_valid,
	input  logic               wt_rsp_ready,

	// merged master side, command
	output icb_pkg::icb_addr_t arb_cmd_addr,
	output logic               arb_cmd_read,
	output icb_pkg::icb_data_t arb_cmd_wdata,
	output icb_pkg::icb_mask_t arb_cmd_wmask,
	output logic               arb_cmd_valid,
	input  logic               arb_cmd_ready,
	// merged master side, response
	input  icb_pkg::icb_data_t arb_rsp_rdata,
	input  logic               arb_rsp_err,
	input  logic               arb_rsp_valid,
	output logic               arb_rsp_ready
);

	import dcache_arb_pkg::*;

	logic       rd_req;          // read wants the port and a tag slot is free
	logic       wt_req;          // same for write
	logic       rd_pick;         // fresh decision, no hold
	logic       rd_grant;
	logic       wt_grant;
	logic       cmd_fire;        // merged command transfers
	logic       pref_wt;         // round-robin pointer, 1 = write next on conflict
	logic       hold_vld;        // last offer stalled
	logic       hold_rd;         // and it belonged to read
	logic       route_in_ready;  // tag queue not full
	logic       route_out_valid; // some command outstanding
	logic       route_out_ready;
	route_tag_t route_push_tag;
	route_tag_t route_head;      // owner of the oldest outstanding command
	logic       rsp_sel_ready;   // ready of the requester the head tag names

	// command side
	assign rd_req = rd_cmd_valid & route_in_ready;
	assign wt_req = wt_cmd_valid & route_in_ready;

	always_comb
	begin
		case (arb_method)
			arb_read_first:  rd_pick = rd_req;
			arb_write_first: rd_pick = rd_req & ~wt_req;
			default:         rd_pick = (rd_req & wt_req) ? ~pref_wt : rd_req;
		endcase
	end

	// a stalled offer keeps its owner so the merged command stays stable
	assign rd_grant = hold_vld ? (hold_rd & rd_req) : rd_pick;
	assign wt_grant = hold_vld ? (~hold_rd & wt_req) : (wt_req & ~rd_pick);

	assign arb_cmd_valid = rd_req | wt_req;
	assign arb_cmd_addr  = rd_grant ? rd_cmd_addr  : wt_cmd_addr;
	assign arb_cmd_read  = rd_grant ? rd_cmd_read  : wt_cmd_read;
	assign arb_cmd_wdata = rd_grant ? rd_cmd_wdata : wt_cmd_wdata;
	assign arb_cmd_wmask = rd_grant ? rd_cmd_wmask : wt_cmd_wmask;

	assign rd_cmd_ready = rd_grant & arb_cmd_ready; // accepted only on merged transfer
	assign wt_cmd_ready = wt_grant & arb_cmd_ready;

	assign cmd_fire       = arb_cmd_valid & arb_cmd_ready;
	assign route_push_tag = rd_grant;

	always_ff @(posedge aclk or negedge aresetn)
	begin
		if (!aresetn)
		begin
			pref_wt  <= 1'b0; // read first after reset
			hold_vld <= 1'b0;
			hold_rd  <= 1'b0;
		end
		else
		begin
			// on a contested transfer the loser is preferred next
			if (cmd_fire & rd_req & wt_req)
				pref_wt <= rd_grant;
			hold_vld <= arb_cmd_valid & ~arb_cmd_ready;
			hold_rd  <= rd_grant;
		end
	end

	// one tag per outstanding command, oldest at the head
	reg_fifo #(
		.payload_t (route_tag_t),
		.depth     (`DCACHE_ROUTE_DEPTH)
	) u_route_q (
		.aclk      (aclk),
		.aresetn   (aresetn),
		.in_valid  (cmd_fire),
		.in_ready  (route_in_ready),
		.in_data   (route_push_tag),
		.out_valid (route_out_valid),
		.out_ready (route_out_ready),
		.out_data  (route_head)
	);

	// response side, memory answers in issue order
	assign rsp_sel_ready = route_head ? rd_rsp_ready : wt_rsp_ready;

	assign rd_rsp_rdata = arb_rsp_rdata;
	assign rd_rsp_err   = arb_rsp_err;   // error goes through as is
	assign rd_rsp_valid = arb_rsp_valid & route_out_valid & route_head;

	assign wt_rsp_rdata = arb_rsp_rdata;
	assign wt_rsp_err   = arb_rsp_err;
	assign wt_rsp_valid = arb_rsp_valid & route_out_valid & ~route_head;

	assign arb_rsp_ready   = route_out_valid & rsp_sel_ready;
	assign route_out_ready = arb_rsp_valid & rsp_sel_ready; // pop on response transfer

	// an offered command has exactly one owner, never two
	a_one_grant: assert property (
		@(posedge aclk) disable iff (!aresetn)
		arb_cmd_valid |-> (rd_grant ^ wt_grant)
	) else $error("merged command without exactly one granted requester");

	// memory side never answers a command that was not issued
	a_rsp_has_tag: assert property (
		@(posedge aclk) disable iff (!aresetn)
		arb_rsp_valid |-> route_out_valid
	) else $error("response with empty route queue");

	// a stalled merged command holds until it transfers
	a_cmd_hold: assert property (
		@(posedge aclk) disable iff (!aresetn)
		(arb_cmd_valid && !arb_cmd_ready) |=>
			(arb_cmd_valid && $stable(arb_cmd_addr) && $stable(arb_cmd_read))
	) else $error("merged command changed while stalled");

endmodule

// ==== reg_fifo.sv ====
// register queue with first-word-fall-through output
// payload type is a parameter, so one body carries tags, commands and responses
`timescale 1ns/100ps

module reg_fifo #(
	parameter type payload_t = logic,
	parameter int  depth     = 2
)(
	input  logic     aclk,
	input  logic     aresetn,

	// write side
	input  logic     in_valid,
	output logic     in_ready,  // not full
	input  payload_t in_data,

	// read side
	output logic     out_valid, // not empty
	input  logic     out_ready,
	output payload_t out_data
);

	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_w = $clog2(depth + 1);

	payload_t             mem [depth]; // entry storage
	logic     [ptr_w-1:0] wr_ptr;      // next slot to fill
	logic     [ptr_w-1:0] rd_ptr;      // current head
	logic     [cnt_w-1:0] count;       // entries held
	logic                 wr_en;
	logic                 rd_en;

	// step a pointer, wrapping at depth
	// depth need not be a power of two
	function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
		if (ptr == ptr_w'(depth - 1))
			return '0;
		else
			return ptr + 1'b1;
	endfunction

	assign in_ready  = (count != cnt_w'(depth));
	assign out_valid = (count != '0);
	assign out_data  = mem[rd_ptr]; // head falls through, no read latency

	assign wr_en = in_valid & in_ready;   // input transfer
	assign rd_en = out_valid & out_ready; // output transfer

	// payload array
	always_ff @(posedge aclk)
	begin
		if (wr_en)
			mem[wr_ptr] <= in_data;
	end

	// pointers and occupancy
	always_ff @(posedge aclk or negedge aresetn)
	begin
		if (!aresetn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0; // empty after reset
		end
		else
		begin
			if (wr_en)
				wr_ptr <= ptr_inc(wr_ptr);
			if (rd_en)
				rd_ptr <= ptr_inc(rd_ptr);

			// simultaneous push and pop keeps the count
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// a full queue with no pop stays full, pointers parked
	a_no_write_full: assert property (
		@(posedge aclk) disable iff (!aresetn)
		(count == cnt_w'(depth) && !rd_en) |=>
			(count == cnt_w'(depth) && $stable(wr_ptr) && $stable(rd_ptr))
	) else $error("reg_fifo write while full");

	// an empty queue with no push stays empty
	a_no_read_empty: assert property (
		@(posedge aclk) disable iff (!aresetn)
		(count == '0 && !wr_en) |=> (count == '0 && $stable(rd_ptr))
	) else $error("reg_fifo read while empty");

	// occupancy within depth and equal to the pointer distance
	a_count_bound: assert property (
		@(posedge aclk) disable iff (!aresetn)
		(count <= cnt_w'(depth)) && (wr_ptr == ptr_w'((rd_ptr + count) % depth))
	) else $error("reg_fifo count above depth");

endmodule

// ==== dcache_arb_pkg.sv ====
// arbitration types of the dcache memory path
// method select and the route tag kept per outstanding command

package dcache_arb_pkg;

	// how the two requesters share the ICB master port
	typedef enum logic [1:0] {
		arb_round_robin = 2'd0, // alternate on conflict
		arb_read_first  = 2'd1, // line fill always wins
		arb_write_first = 2'd2  // write-back always wins
	} arb_method_e;

	// one tag per accepted command
	// set when the line-fill (read) requester owns it
	typedef logic route_tag_t;

endpackage

// ==== icb_pkg.sv ====
// ICB field types and command/response payloads
// payload structs are what the register slices carry

package icb_pkg;

	typedef logic [31:0] icb_addr_t; // byte address
	typedef logic [31:0] icb_data_t; // one data word
	typedef logic [3:0]  icb_mask_t; // one bit per byte lane

	// command channel payload, 69 bits
	typedef struct packed {
		icb_addr_t addr;  // byte address
		logic      read;  // 1 read, 0 write
		icb_data_t wdata; // ignored on reads
		icb_mask_t wmask; // byte enables for writes
	} icb_cmd_t;

	// response channel payload, 33 bits
	typedef struct packed {
		icb_data_t rdata; // read data
		logic      err;   // slave error, passed on untouched
	} icb_rsp_t;

endpackage

// ==== dcache_mem_cfg.svh ====
// build-time settings of the dcache next-level memory path
// queue depths and default arbitration
`ifndef DCACHE_MEM_CFG_SVH
`define DCACHE_MEM_CFG_SVH

// route-tag queue depth
// also the limit on commands in flight toward memory
`define DCACHE_ROUTE_DEPTH 4

// command and response register slices
`define DCACHE_SLICE_DEPTH 2

// arbitration between line fill and write-back
// one of arb_round_robin, arb_read_first, arb_write_first
`define DCACHE_ARB_METHOD dcache_arb_pkg::arb_round_robin

`endif
